// ==== hdl/rv_pkg.sv ====
// shared rv64i types and bus structs; memory is one 64-bit word per 8 bytes, doubleword data only
package rv_pkg;

    typedef logic [63:0] xlen_t;     // data word or byte address
    typedef logic [31:0] inst_t;     // one instruction word
    typedef logic [4:0]  reg_idx_t;  // register number x0..x31

    localparam xlen_t RESET_PC = 64'h0;            // first fetch address
    localparam inst_t NOP_INST = 32'h0000_0013;    // addi x0,x0,0

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,   // signed
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B // b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_BUSY,  // fetch cycle on the bus, data wanted
        FETCH_DROP   // fetch cycle on the bus, data thrown away after redirect
    } fetch_state_e;

    typedef enum logic {
        LSU_IDLE,
        LSU_BUSY
    } lsu_state_e;

    // wishbone classic request from a master
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        xlen_t adr;
        xlen_t dat;
    } wb_req_t;

    // wishbone classic response from a slave
    typedef struct packed {
        logic  ack;
        xlen_t dat;  // read data, valid with ack
    } wb_rsp_t;

endpackage

// ==== hdl/alu.sv ====
// combinational 64-bit alu; shifts use b[5:0], compare outputs are independent of op
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  alu_op_e op,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   result,
    output logic    cmp_eq,
    output logic    cmp_lt
);

    logic [5:0] shamt;
    logic       lt_s;   // signed a < b
    logic       lt_u;   // unsigned a < b

    assign shamt = b[5:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {63'b0, lt_s};
            ALU_SLTU: result = {63'b0, lt_u};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);  // sign fill
            ALU_PASS_B: result = b;
            default:  result = a + b;
        endcase
    end

    // beq/bne from eq, blt/bge from signed lt
    assign cmp_eq = (a == b);
    assign cmp_lt = lt_s;

endmodule

// ==== hdl/reg_file.sv ====
// 32 x 64 register file, combinational reads, write at the clock edge, no write-to-read bypass
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic     clk_1hz,
    input  logic     reset_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     wen,
    input  xlen_t    wdata,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [32];  // entry 0 never written

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;   // writes to x0 dropped
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];  // x0 reads zero
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/bus_arbiter.sv ====
// two masters onto one wishbone classic port with data link priority and no retry or error support
`timescale 1ns/1ps

module bus_arbiter import rv_pkg::*; (
    input  logic    clk_1hz,
    input  logic    reset_n,
    input  wb_req_t fetch_req,
    output wb_rsp_t fetch_rsp,
    input  wb_req_t data_req,
    output wb_rsp_t data_rsp,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp
);

    logic lock_q;      // a granted cycle is still waiting for ack
    logic gnt_data_q;  // owner of the locked cycle
    logic sel_data;    // current owner with 1 for the data link

    // free bus picks data first, else fetch (fetch also when nobody asks)
    assign sel_data = lock_q ? gnt_data_q : data_req.cyc;

    assign wb_req = sel_data ? data_req : fetch_req;

    // ack only to the owner while read data fans out to both
    assign fetch_rsp.ack = wb_rsp.ack && !sel_data;
    assign fetch_rsp.dat = wb_rsp.dat;
    assign data_rsp.ack  = wb_rsp.ack && sel_data;
    assign data_rsp.dat  = wb_rsp.dat;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            lock_q     <= 1'b0;
            gnt_data_q <= 1'b0;
        end else if (wb_req.cyc && !wb_rsp.ack) begin
            lock_q     <= 1'b1;      // hold owner until the ack
            gnt_data_q <= sel_data;
        end else begin
            lock_q     <= 1'b0;      // released in the ack cycle
        end
    end

    a_stb_needs_cyc: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        wb_req.stb |-> wb_req.cyc);

    // owner and its request held under an open cycle
    a_grant_stable: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (wb_req.cyc && !wb_rsp.ack) |=> $stable(wb_req));

endmodule

// ==== hdl/fetch_unit.sv ====
// fetch with one instruction slot and one cycle ahead; a fetch that finds the slot busy is refetched
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; (
    input  logic    clk_1hz,
    input  logic    reset_n,
    output wb_req_t fetch_req,
    input  wb_rsp_t fetch_rsp,
    output inst_t   inst,
    output xlen_t   inst_pc,
    output logic    inst_valid,
    input  logic    take,
    input  logic    redirect,
    input  xlen_t   redirect_pc
);

    fetch_state_e state_q;
    xlen_t        pc_q;      // address of the next instruction to accept
    xlen_t        adr_q;     // address of the cycle on the bus
    inst_t        inst_q;    // instruction register
    xlen_t        inst_pc_q;
    logic         valid_q;
    logic         slot_free; // slot empty or emptied this cycle
    inst_t        word;      // 32-bit half picked from the memory word

    assign slot_free = !valid_q || take;
    assign word      = adr_q[2] ? fetch_rsp.dat[63:32] : fetch_rsp.dat[31:0];

    assign fetch_req.cyc = (state_q != FETCH_IDLE);
    assign fetch_req.stb = (state_q != FETCH_IDLE);
    assign fetch_req.we  = 1'b0;          // read only
    assign fetch_req.adr = adr_q;
    assign fetch_req.dat = '0;

    assign inst       = inst_q;
    assign inst_pc    = inst_pc_q;
    assign inst_valid = valid_q;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= FETCH_IDLE;
            pc_q      <= RESET_PC;
            adr_q     <= RESET_PC;
            inst_q    <= NOP_INST;
            inst_pc_q <= RESET_PC;
            valid_q   <= 1'b0;
        end else begin
            if (take) valid_q <= 1'b0;   // consumed unless reloaded below
            case (state_q)
                FETCH_IDLE: begin
                    if (redirect) begin
                        pc_q    <= redirect_pc;
                        adr_q   <= redirect_pc;
                        state_q <= FETCH_BUSY;
                    end else if (slot_free) begin
                        adr_q   <= pc_q;     // retry or continue at pc
                        state_q <= FETCH_BUSY;
                    end
                end
                FETCH_BUSY: begin
                    if (redirect) begin
                        pc_q <= redirect_pc;
                        if (fetch_rsp.ack) adr_q <= redirect_pc;   // restart at once
                        else state_q <= FETCH_DROP;               // wait out the old cycle
                    end else if (fetch_rsp.ack) begin
                        if (slot_free) begin
                            inst_q    <= word;
                            inst_pc_q <= adr_q;
                            valid_q   <= 1'b1;
                            pc_q      <= adr_q + 64'd4;
                            adr_q     <= adr_q + 64'd4;   // back to back prefetch
                        end else begin
                            state_q <= FETCH_IDLE;       // slot full, refetch same pc
                        end
                    end
                end
                default: begin   // FETCH_DROP
                    if (redirect) pc_q <= redirect_pc;
                    if (fetch_rsp.ack) begin
                        adr_q   <= redirect ? redirect_pc : pc_q;
                        state_q <= FETCH_BUSY;
                    end
                end
            endcase
            if (redirect) valid_q <= 1'b0;   // flush the instruction behind the jump
        end
    end

    a_adr_stable: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        (fetch_req.cyc && !fetch_rsp.ack) |=> (fetch_req.cyc && $stable(fetch_req.adr)));

endmodule

// ==== hdl/load_store_unit.sv ====
// one wishbone data cycle per request, whole doublewords only, a new request waits for done
`timescale 1ns/1ps

module load_store_unit import rv_pkg::*; (
    input  logic    clk_1hz,
    input  logic    reset_n,
    input  logic    mem_go,
    input  logic    mem_we,
    input  xlen_t   mem_addr,
    input  xlen_t   mem_wdata,
    output logic    mem_done,
    output xlen_t   mem_rdata,
    output wb_req_t data_req,
    input  wb_rsp_t data_rsp
);

    lsu_state_e state_q;
    logic       we_q;
    xlen_t      adr_q;    // held for the whole cycle
    xlen_t      dat_q;
    xlen_t      rdata_q;  // last load value

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= LSU_IDLE;
            we_q    <= 1'b0;
        end else if (state_q == LSU_IDLE) begin
            if (mem_go) begin
                state_q <= LSU_BUSY;
                we_q    <= mem_we;
            end
        end else if (data_rsp.ack) begin
            state_q <= LSU_IDLE;
        end
    end

    always_ff @(posedge clk_1hz) begin
        if ((state_q == LSU_IDLE) && mem_go) begin
            adr_q <= mem_addr;
            dat_q <= mem_wdata;
        end
        if (mem_done) rdata_q <= data_rsp.dat;
    end

    assign data_req.cyc = (state_q == LSU_BUSY);
    assign data_req.stb = (state_q == LSU_BUSY);
    assign data_req.we  = we_q;
    assign data_req.adr = adr_q;
    assign data_req.dat = dat_q;

    assign mem_done  = (state_q == LSU_BUSY) && data_rsp.ack;   // same cycle as ack
    assign mem_rdata = mem_done ? data_rsp.dat : rdata_q;       // live in the ack cycle

endmodule

// ==== hdl/execute_stage.sv ====
// decode and execute of the rv64i subset; unknown opcodes retire as nops, ld/sd stall until done
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  logic     clk_1hz,
    input  logic     reset_n,
    input  inst_t    inst,
    input  xlen_t    inst_pc,
    input  logic     inst_valid,
    output logic     take,
    output logic     redirect,
    output xlen_t    redirect_pc,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  xlen_t    rdata1,
    input  xlen_t    rdata2,
    output reg_idx_t rd,
    output logic     wen,
    output xlen_t    wdata,
    output alu_op_e  alu_op,
    output xlen_t    alu_a,
    output xlen_t    alu_b,
    input  xlen_t    alu_result,
    input  logic     cmp_eq,
    input  logic     cmp_lt,
    output logic     mem_go,
    output logic     mem_we,
    output xlen_t    mem_addr,
    output xlen_t    mem_wdata,
    input  logic     mem_done,
    input  xlen_t    mem_rdata
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t      pc_plus4;
    logic       is_mem;     // ld or sd
    logic       br_taken;
    logic       writes_rd;
    logic       issued_q;   // data request already sent for this ld/sd

    // funct3 to alu op, sub only for the register form
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt, input logic is_reg);
        case (f3)
            3'b000:  f3_op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign pc_plus4 = inst_pc + 64'd4;

    always_comb begin
        alu_a  = rdata1;    // register operands unless overridden
        alu_b  = rdata2;
        alu_op = ALU_ADD;
        case (opcode)
            OPC_OP:     alu_op = f3_op(funct3, inst[30], 1'b1);
            OPC_OP_IMM: begin
                alu_b  = imm_i;
                alu_op = f3_op(funct3, inst[30], 1'b0);
            end
            OPC_LOAD:   alu_b = imm_i;          // effective address
            OPC_STORE:  alu_b = imm_s;
            OPC_AUIPC: begin
                alu_a = inst_pc;
                alu_b = imm_u;
            end
            OPC_LUI:    alu_op = ALU_PASS_B;    // wdata takes imm_u directly
            OPC_BRANCH: alu_op = ALU_SUB;       // only the compare flags matter
            default:    ;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_taken = cmp_eq;    // beq
            3'b001:  br_taken = !cmp_eq;   // bne
            3'b100:  br_taken = cmp_lt;    // blt
            3'b101:  br_taken = !cmp_lt;   // bge
            default: br_taken = 1'b0;
        endcase
    end

    assign is_mem = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
    assign take   = inst_valid && (!is_mem || mem_done);   // ld/sd wait for the bus

    assign redirect = take && ((opcode == OPC_JAL) || ((opcode == OPC_BRANCH) && br_taken));
    assign redirect_pc = inst_pc + ((opcode == OPC_JAL) ? imm_j : imm_b);

    assign writes_rd = (opcode == OPC_LUI) || (opcode == OPC_AUIPC) || (opcode == OPC_OP)
                    || (opcode == OPC_OP_IMM) || (opcode == OPC_LOAD) || (opcode == OPC_JAL);
    assign wen = take && writes_rd;

    always_comb begin
        case (opcode)
            OPC_LUI:  wdata = imm_u;
            OPC_JAL:  wdata = pc_plus4;    // link address
            OPC_LOAD: wdata = mem_rdata;
            default:  wdata = alu_result;
        endcase
    end

    // one data request per ld/sd
    assign mem_go    = inst_valid && is_mem && !issued_q;
    assign mem_we    = (opcode == OPC_STORE);
    assign mem_addr  = alu_result;
    assign mem_wdata = rdata2;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) issued_q <= 1'b0;
        else if (mem_done) issued_q <= 1'b0;
        else if (mem_go) issued_q <= 1'b1;
    end

    a_target_aligned: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        redirect |-> (redirect_pc[1:0] == 2'b00));

endmodule

// ==== hdl/cpu_top.sv ====
// two-stage rv64i core with a single wishbone classic master port to unified memory
`timescale 1ns/1ps

module cpu_top import rv_pkg::*; (
    input  logic    clk_1hz,
    input  logic    reset_n,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp
);

    wb_req_t  fetch_req, data_req;
    wb_rsp_t  fetch_rsp, data_rsp;
    inst_t    inst;
    xlen_t    inst_pc, redirect_pc;
    logic     inst_valid, take, redirect;
    reg_idx_t rs1, rs2, rd;
    xlen_t    rdata1, rdata2, wdata;
    logic     wen;
    alu_op_e  alu_op;
    xlen_t    alu_a, alu_b, alu_result;
    logic     cmp_eq, cmp_lt;
    logic     mem_go, mem_we, mem_done;
    xlen_t    mem_addr, mem_wdata, mem_rdata;

    fetch_unit i_fetch_unit (
        .clk_1hz, .reset_n, .fetch_req, .fetch_rsp, .inst, .inst_pc, .inst_valid,
        .take, .redirect, .redirect_pc
    );

    execute_stage i_execute_stage (
        .clk_1hz, .reset_n, .inst, .inst_pc, .inst_valid, .take, .redirect, .redirect_pc,
        .rs1, .rs2, .rdata1, .rdata2, .rd, .wen, .wdata, .alu_op, .alu_a, .alu_b,
        .alu_result, .cmp_eq, .cmp_lt, .mem_go, .mem_we, .mem_addr, .mem_wdata,
        .mem_done, .mem_rdata
    );

    reg_file i_reg_file (
        .clk_1hz, .reset_n, .rs1, .rs2, .rd, .wen, .wdata, .rdata1, .rdata2
    );

    alu i_alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .cmp_eq, .cmp_lt
    );

    load_store_unit i_load_store_unit (
        .clk_1hz, .reset_n, .mem_go, .mem_we, .mem_addr, .mem_wdata, .mem_done,
        .mem_rdata, .data_req, .data_rsp
    );

    bus_arbiter i_bus_arbiter (
        .clk_1hz, .reset_n, .fetch_req, .fetch_rsp, .data_req, .data_rsp, .wb_req, .wb_rsp
    );

endmodule

// ==== dv/tb_checker.sv ====
// instruction-set model of the kept rv64i subset; compares each bus write with the model's stores
`timescale 1ns/1ps

module tb_checker import rv_pkg::*; #(
    parameter int    PROG_LEN  = 300,
    parameter xlen_t DATA_BASE = 64'h1000
) (
    input  logic    clk_1hz,
    input  logic    reset_n,
    input  wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    input  logic    image_ready,
    output logic    done,
    output int      error_count,
    output int      store_count
);

    localparam int    LIMIT     = PROG_LEN * 20;             // cycles after reset
    localparam xlen_t FINAL_PC  = xlen_t'((PROG_LEN - 1) * 4);
    localparam int    LOOP_SEEN = 10;   // fetch acks of the final jal that end the run

    xlen_t exp_addr [$];   // expected stores in program order
    xlen_t exp_data [$];
    int    cycles;
    int    final_fetches;

    function automatic xlen_t reg_op(input logic [2:0] f3, input logic alt,
                                     input xlen_t a, input xlen_t b);
        logic signed [63:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: return (a < b) ? 64'd1 : 64'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (!alt) return a >> b[5:0];
                sa = sa >>> b[5:0];   // arithmetic
                return sa;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        xlen_t      regs [32];
        xlen_t      dm [1024];
        xlen_t      pc, next_pc, a, b, res, ea, imm_b, imm_j;
        inst_t      ins;
        logic [6:0] opc;
        logic       taken;
        logic       stop;
        int         steps;
        for (int k = 0; k < 32; k++) regs[5'(k)] = '0;
        for (int k = 0; k < 1024; k++) dm[10'(k)] = tb_top.mem[10'(k)];
        pc    = RESET_PC;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 100000) begin
            ins   = pc[2] ? dm[pc[12:3]][63:32] : dm[pc[12:3]][31:0];
            opc   = ins[6:0];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            res     = '0;
            next_pc = pc + 64'd4;
            steps++;
            case (opc)
                OPC_LUI:    res = {{32{ins[31]}}, ins[31:12], 12'b0};
                OPC_AUIPC:  res = pc + {{32{ins[31]}}, ins[31:12], 12'b0};
                OPC_OP:     res = reg_op(ins[14:12], ins[30], a, b);
                OPC_OP_IMM: res = reg_op(ins[14:12], 1'b0, a, {{52{ins[31]}}, ins[31:20]});
                OPC_LOAD: begin
                    ea  = a + {{52{ins[31]}}, ins[31:20]};
                    res = dm[ea[12:3]];
                end
                OPC_STORE: begin
                    ea = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    dm[ea[12:3]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                OPC_BRANCH: begin
                    case (ins[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        default: taken = ($signed(a) >= $signed(b));   // bge
                    endcase
                    if (taken) next_pc = pc + imm_b;
                end
                OPC_JAL: begin
                    res     = pc + 64'd4;   // link
                    next_pc = pc + imm_j;
                    stop    = (imm_j == '0);   // final self loop
                end
                default: ;
            endcase
            if ((opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_OP || opc == OPC_OP_IMM
                    || opc == OPC_LOAD || opc == OPC_JAL) && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;   // x0 stays zero
            end
            pc = next_pc;
        end
        if (!stop) begin
            error_count++;
            $display("model did not reach the final loop within %0d instructions", steps);
        end
    endtask

    task automatic check_store(input xlen_t adr, input xlen_t dat);
        if (adr < DATA_BASE || adr >= DATA_BASE + 64'd256 || adr[2:0] != 3'd0) begin
            error_count++;
            $display("store to %h at %0t is outside the data window or unaligned", adr, $time);
        end
        if (store_count >= exp_addr.size()) begin
            error_count++;
            $display("extra store to %h at %0t that the model does not make", adr, $time);
        end else if (adr != exp_addr[store_count] || dat != exp_data[store_count]) begin
            error_count++;
            $display("FAIL %0t: store %0d at %h data %h, expected %h data %h", $time,
                     store_count, adr, dat, exp_addr[store_count], exp_data[store_count]);
        end
        store_count++;
    endtask

    initial begin
        done          = 1'b0;
        error_count   = 0;
        store_count   = 0;
        cycles        = 0;
        final_fetches = 0;
        wait (image_ready);
        run_model();
        while (!done) begin
            @(posedge clk_1hz);
            if (!reset_n) begin
                if (wb_req.cyc) begin
                    error_count++;
                    $display("bus cycle started while reset_n was low at %0t", $time);
                end
            end else begin
                cycles++;
                if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
                    if (wb_req.we) check_store(wb_req.adr, wb_req.dat);
                    else if (wb_req.adr == FINAL_PC) final_fetches++;   // looping at the end
                end
                if (final_fetches >= LOOP_SEEN) begin
                    if (store_count < exp_addr.size()) begin
                        error_count++;
                        $display("missing stores, %0d of %0d seen at the final loop",
                                 store_count, exp_addr.size());
                    end
                    done = 1'b1;
                end else if (cycles >= LIMIT) begin
                    error_count++;
                    $display("timeout after %0d cycles before the final loop", cycles);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

// ==== dv/tb_top.sv ====
// random program in a 1024-doubleword memory, data window at 0x1000, 0 to 3 wait states per cycle
`timescale 1ns/1ps

module tb_top import rv_pkg::*; ();

    localparam int    PROG_LEN  = 300;        // instructions, the last one loops on itself
    localparam int    MEM_WORDS = 1024;       // 8 kbyte
    localparam xlen_t DATA_BASE = 64'h1000;   // 256-byte window, loaded into x1 by lui

    logic        clk_1hz;
    logic        reset_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    xlen_t       mem [MEM_WORDS];   // read by the checker too
    logic [15:0] lfsr_q;
    logic        image_ready;       // program and data built
    logic        done;
    int          error_count;
    int          store_count;

    cpu_top i_cpu_top (.clk_1hz, .reset_n, .wb_req, .wb_rsp);

    tb_checker #(.PROG_LEN(PROG_LEN), .DATA_BASE(DATA_BASE)) i_tb_checker (
        .clk_1hz, .reset_n, .wb_req, .wb_rsp, .image_ready, .done, .error_count, .store_count
    );

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);   // one step per bit
            v      = {v[62:0], lfsr_q[0]};
        end
    endtask

    task automatic put_inst(input int idx, input inst_t w);
        if (idx[0]) mem[10'(idx / 2)][63:32] = w;   // odd slot in the upper half
        else mem[10'(idx / 2)][31:0] = w;
    endtask

    task automatic gen_inst(input int i, output inst_t w);
        logic [63:0] r;
        logic [3:0]  kind;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] off;
        logic [12:0] boff;
        logic [20:0] joff;
        int          step;
        rand_bits(4, r);
        kind = r[3:0];
        rand_bits(5, r);
        rd = (r[4:0] == 5'd1) ? 5'd0 : r[4:0];   // x1 keeps the base, x0 writes stay in
        rand_bits(5, r);
        rs1 = r[4:0];
        rand_bits(5, r);
        rs2 = r[4:0];
        rand_bits(3, r);
        f3 = r[2:0];
        rand_bits(3, r);
        step = 2 + int'(r[2:0]) % 7;                  // forward 8 to 32 bytes
        if (kind >= 4'd13 && i > PROG_LEN - 10) kind = 4'd0;   // never past the final loop
        case (kind)
            4'd0, 4'd1, 4'd2: begin   // register alu group
                rand_bits(1, r);
                f7 = (r[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                w  = {f7, rs2, rs1, f3, rd, OPC_OP};
            end
            4'd3, 4'd4, 4'd5: begin   // addi xori ori andi
                rand_bits(12, r);
                f3 = (f3[1:0] == 2'd0) ? 3'd0 : {1'b1, f3[1], f3[1] & f3[0]};
                w  = {r[11:0], rs1, f3, rd, OPC_OP_IMM};
            end
            4'd6: begin
                rand_bits(20, r);
                w = {r[19:0], rd, OPC_LUI};
            end
            4'd7: begin
                rand_bits(20, r);
                w = {r[19:0], rd, OPC_AUIPC};
            end
            4'd8, 4'd9: begin         // ld rd, off(x1)
                rand_bits(5, r);
                w = {4'b0, r[4:0], 3'b0, 5'd1, 3'b011, rd, OPC_LOAD};
            end
            4'd10, 4'd11, 4'd12: begin   // sd rs2, off(x1)
                rand_bits(5, r);
                off = {4'b0, r[4:0], 3'b0};
                w   = {off[11:5], rs2, 5'd1, 3'b011, off[4:0], OPC_STORE};
            end
            4'd13, 4'd14: begin       // beq bne blt bge
                boff = 13'(step * 4);
                f3   = {f3[1], 1'b0, f3[0]};
                w = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
            end
            default: begin
                joff = 21'(step * 4);
                w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            end
        endcase
    endtask

    task automatic build_image();
        logic [63:0] r;
        inst_t       w;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[10'(a)] = 64'(a) * 64'h9e37_79b9_7f4a_7c15;   // background from the address
        end
        for (int a = 0; a < 32; a++) begin
            rand_bits(64, r);
            mem[10'(int'(DATA_BASE / 8) + a)] = r;
        end
        put_inst(0, {DATA_BASE[31:12], 5'd1, OPC_LUI});   // lui x1
        for (int i = 1; i < PROG_LEN - 1; i++) begin
            gen_inst(i, w);
            put_inst(i, w);
        end
        put_inst(PROG_LEN - 1, {25'b0, OPC_JAL});   // jal x0, 0
    endtask

    initial begin
        clk_1hz = 1'b0;
        forever #50 clk_1hz = ~clk_1hz;
    end

    // memory slave, acts on the falling edge
    initial begin
        logic [63:0] r;
        logic        busy;
        int          wait_left;
        wb_rsp      = '0;
        lfsr_q      = 16'd8808;
        image_ready = 1'b0;
        busy        = 1'b0;
        wait_left   = 0;
        build_image();
        image_ready = 1'b1;
        forever begin
            @(negedge clk_1hz);
            wb_rsp.ack = 1'b0;   // one-cycle ack
            if (reset_n && wb_req.cyc && wb_req.stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    rand_bits(2, r);
                    wait_left = int'(r[1:0]);
                end
                if (wait_left == 0) begin
                    busy       = 1'b0;
                    wb_rsp.ack = 1'b1;
                    if (wb_req.we) mem[wb_req.adr[12:3]] = wb_req.dat;
                    else wb_rsp.dat = mem[wb_req.adr[12:3]];
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk_1hz);
        @(negedge clk_1hz);
        reset_n = 1'b1;
        wait (done);   // checker ends at the final loop or on its cycle limit
        $display("stores checked %0d, errors %0d", store_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/rv_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/bus_arbiter.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/execute_stage.sv
hdl/cpu_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the core testbench with Verilator; exit status follows the log search
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_top -o sim_tb_top
./obj_dir/sim_tb_top | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
